// File: trace_settings.svh
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// threshold DAC word width
`define THR_W 16

// delay line code width
`define DCODE_W 10

// default strobe period in clocks for a zero period_i
`define STB_PERIOD 16

// number of points held before overflow
`define POINT_FIFO_DEPTH 8

`endif

// File: trace_pkg.sv
`include "trace_settings.svh"

package trace_pkg;

    // data words
    typedef logic [`THR_W-1:0]   threshold_t;
    typedef logic [`DCODE_W-1:0] dcode_t;
    typedef logic [15:0]         period_t;

    // controller top level
    typedef enum logic {IDLE, RUN} ctl_state_t;

    // search phase and direction
    typedef enum logic {FIND_VAL, FIND_DIRECTION} measure_state_t;
    typedef enum logic {UP, DOWN} direction_t;

    // handshake FSMs
    typedef enum logic [1:0] {DAC_IDLE, DAC_REQ, DAC_RELEASE} dac_state_t;
    typedef enum logic [1:0] {OUT_IDLE, OUT_REQ, OUT_WAIT_LOW} out_state_t;

endpackage

// File: strobe_gen.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module strobe_gen
    import trace_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_i,
    input  logic    run_i,
    input  period_t period_i,
    output logic    stb_o
);

    localparam period_t DEFAULT_PERIOD = period_t'(`STB_PERIOD);

    period_t eff_period;
    period_t cnt;

    // zero period falls back to the default
    assign eff_period = (period_i == '0) ? DEFAULT_PERIOD : period_i;

    always_ff @(posedge clk_i, posedge arst_i) begin
        if (arst_i) begin
            cnt   <= '0;
            stb_o <= 1'b0;
        end else begin
            stb_o <= 1'b0;
            if (!run_i) begin
                // held at zero so a new run starts a full period
                cnt <= '0;
            end else if (cnt >= eff_period) begin
                cnt   <= period_t'(1);
                stb_o <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: dac_link.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module dac_link
    import trace_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_i,
    input  logic       wre_i,
    input  threshold_t data_i,
    output logic       rdy_o,
    output logic       dac_req_o,
    output threshold_t dac_data_o,
    input  logic       dac_ack_i
);

    dac_state_t state;
    logic       pend;
    threshold_t pend_data;

    // converter holds the latest requested value
    assign rdy_o = (state == DAC_IDLE) && !dac_ack_i && !pend;

    always_ff @(posedge clk_i, posedge arst_i) begin
        if (arst_i) begin
            state      <= DAC_IDLE;
            dac_req_o  <= 1'b0;
            dac_data_o <= '0;
            pend       <= 1'b0;
        end else begin
            // write during an exchange waits for the next idle slot
            if (wre_i && state != DAC_IDLE) begin
                pend <= 1'b1;
            end
            case (state)
                DAC_IDLE: begin
                    if (wre_i || pend) begin
                        dac_data_o <= wre_i ? data_i : pend_data;
                        dac_req_o  <= 1'b1;
                        pend       <= 1'b0;
                        state      <= DAC_REQ;
                    end
                end
                DAC_REQ: begin
                    if (dac_ack_i) begin
                        dac_req_o <= 1'b0;
                        state     <= DAC_RELEASE;
                    end
                end
                DAC_RELEASE: begin
                    if (!dac_ack_i) state <= DAC_IDLE;
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wre_i && state != DAC_IDLE) pend_data <= data_i;
    end

endmodule

// File: ch_measure_ctl.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module ch_measure_ctl
    import trace_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_i,

    // sampling strobe and comparator
    input  logic       stb_i,
    input  logic       cmp_out_i,

    input  logic       run_i,

    // search steps
    input  threshold_t threshold_delta_i,
    input  dcode_t     d_code_delta_i,

    // threshold DAC side
    output threshold_t threshold_o,
    output logic       threshold_wre_o,
    input  logic       threshold_rdy_i,

    // delay line code
    output dcode_t     d_code_o,

    // measured point
    output logic       point_rdy_o,
    output threshold_t point_v_o,
    output dcode_t     point_t_o
);

    ctl_state_t     state;
    measure_state_t measure_state;
    direction_t     dir;

    logic stb_prev;
    logic stb_posedge;
    logic cmp_prev;
    logic accept;
    logic crossing;

////////////////////
    // strobe edges count only with a settled DAC
    assign stb_posedge = stb_i && !stb_prev;
    assign accept      = stb_posedge && threshold_rdy_i && (state == RUN) && run_i;
    assign crossing    = accept && (measure_state == FIND_VAL) && (cmp_out_i != cmp_prev);

    always_ff @(posedge clk_i, posedge arst_i) begin
        if (arst_i) begin
            stb_prev <= 1'b0;
        end else begin
            stb_prev <= stb_i;
        end
    end

////////////////////
    always_ff @(posedge clk_i, posedge arst_i) begin
        if (arst_i) begin
            state           <= IDLE;
            measure_state   <= FIND_VAL;
            dir             <= UP;
            cmp_prev        <= 1'b1;
            threshold_o     <= '0;
            threshold_wre_o <= 1'b0;
            d_code_o        <= '0;
            point_rdy_o     <= 1'b0;
        end else begin
            threshold_wre_o <= 1'b0;
            point_rdy_o     <= 1'b0;
            case (state)
                IDLE: begin
                    if (run_i) begin
                        // fresh sweep from zero threshold and code 0
                        state           <= RUN;
                        measure_state   <= FIND_VAL;
                        dir             <= UP;
                        cmp_prev        <= 1'b1;
                        threshold_o     <= '0;
                        d_code_o        <= '0;
                        threshold_wre_o <= 1'b1;
                    end
                end
                RUN: begin
                    if (!run_i) begin
                        state <= IDLE;
                    end else if (accept) begin
                        cmp_prev <= cmp_out_i;
                        case (measure_state)
                            FIND_VAL: begin
                                if (crossing) begin
                                    point_rdy_o   <= 1'b1;
                                    d_code_o      <= d_code_o + d_code_delta_i;
                                    measure_state <= FIND_DIRECTION;
                                end else begin
                                    threshold_o <= (dir == UP) ?
                                                   threshold_o + threshold_delta_i :
                                                   threshold_o - threshold_delta_i;
                                    threshold_wre_o <= 1'b1;
                                end
                            end
                            FIND_DIRECTION: begin
                                // signal moved across the code step
                                if (cmp_out_i && !cmp_prev) begin
                                    dir <= UP;
                                end else if (!cmp_out_i && cmp_prev) begin
                                    dir <= DOWN;
                                end else begin
                                    dir <= (dir == UP) ? DOWN : UP;
                                end
                                measure_state <= FIND_VAL;
                            end
                            default: measure_state <= FIND_VAL;
                        endcase
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // point payload
    always_ff @(posedge clk_i) begin
        if (crossing) begin
            point_v_o <= threshold_o;
            point_t_o <= d_code_o;
        end
    end

endmodule

// File: point_fifo.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module point_fifo
    import trace_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_i,
    input  logic       push_i,
    input  threshold_t v_i,
    input  dcode_t     t_i,
    output logic       point_req_o,
    output threshold_t point_v_o,
    output dcode_t     point_t_o,
    input  logic       point_ack_i,
    output logic       overflow_o
);

    localparam int DEPTH = `POINT_FIFO_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    threshold_t v_mem [DEPTH];
    dcode_t     t_mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    out_state_t    out_state;

    logic full;
    logic push_ok;
    logic pop;
    logic present;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1)) return '0;
        return p + 1'b1;
    endfunction

    assign full    = (count == (AW+1)'(DEPTH));
    assign push_ok = push_i && !full;
    assign pop     = (out_state == OUT_REQ) && point_ack_i;
    assign present = (out_state == OUT_IDLE) && (count != '0);

    always_ff @(posedge clk_i, posedge arst_i) begin
        if (arst_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            out_state   <= OUT_IDLE;
            point_req_o <= 1'b0;
            overflow_o  <= 1'b0;
        end else begin
            if (push_ok) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            count <= count + (AW+1)'(push_ok) - (AW+1)'(pop);
            // sticky until reset
            if (push_i && full) overflow_o <= 1'b1;

            case (out_state)
                OUT_IDLE: begin
                    if (present) begin
                        point_req_o <= 1'b1;
                        out_state   <= OUT_REQ;
                    end
                end
                OUT_REQ: begin
                    if (point_ack_i) begin
                        point_req_o <= 1'b0;
                        out_state   <= OUT_WAIT_LOW;
                    end
                end
                OUT_WAIT_LOW: begin
                    if (!point_ack_i) out_state <= OUT_IDLE;
                end
                default: out_state <= OUT_IDLE;
            endcase
        end
    end

    // storage and head entry
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            v_mem[wr_ptr] <= v_i;
            t_mem[wr_ptr] <= t_i;
        end
        if (present) begin
            point_v_o <= v_mem[rd_ptr];
            point_t_o <= t_mem[rd_ptr];
        end
    end

endmodule

// File: scope_channel_top.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module scope_channel_top
    import trace_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_i,
    input  logic       run_i,
    input  period_t    period_i,
    input  threshold_t threshold_delta_i,
    input  dcode_t     d_code_delta_i,
    input  logic       cmp_i,
    output logic       dac_req_o,
    output threshold_t dac_data_o,
    input  logic       dac_ack_i,
    output dcode_t     d_code_o,
    output logic       point_req_o,
    output threshold_t point_v_o,
    output dcode_t     point_t_o,
    input  logic       point_ack_i,
    output logic       overflow_o
);

    logic       stb;
    threshold_t threshold;
    logic       threshold_wre;
    logic       threshold_rdy;
    logic       point_rdy;
    threshold_t point_v;
    dcode_t     point_t;

    strobe_gen u_strobe_gen (
        .clk_i(clk_i), .arst_i(arst_i), .run_i(run_i), .period_i(period_i), .stb_o(stb)
    );

    dac_link u_dac_link (
        .clk_i(clk_i), .arst_i(arst_i), .wre_i(threshold_wre), .data_i(threshold),
        .rdy_o(threshold_rdy), .dac_req_o(dac_req_o), .dac_data_o(dac_data_o),
        .dac_ack_i(dac_ack_i)
    );

    ch_measure_ctl u_ctl (
        .clk_i(clk_i), .arst_i(arst_i), .stb_i(stb), .cmp_out_i(cmp_i), .run_i(run_i),
        .threshold_delta_i(threshold_delta_i), .d_code_delta_i(d_code_delta_i),
        .threshold_o(threshold), .threshold_wre_o(threshold_wre),
        .threshold_rdy_i(threshold_rdy), .d_code_o(d_code_o),
        .point_rdy_o(point_rdy), .point_v_o(point_v), .point_t_o(point_t)
    );

    point_fifo u_point_fifo (
        .clk_i(clk_i), .arst_i(arst_i), .push_i(point_rdy), .v_i(point_v), .t_i(point_t),
        .point_req_o(point_req_o), .point_v_o(point_v_o), .point_t_o(point_t_o),
        .point_ack_i(point_ack_i), .overflow_o(overflow_o)
    );

endmodule

// File: tb_scope_channel.sv
`timescale 1ns/1ps
`include "trace_settings.svh"

module tb_scope_channel
    import trace_pkg::*;
();

    localparam int CLK_NS        = 4;
    localparam int MAX_PERIOD    = 20;
    // full search from zero plus crossing and direction strobes
    localparam int STB_PER_POINT = 24;
    localparam int TOTAL_POINTS  = 40;
    // doubled to allow for strobes skipped while the DAC is busy
    localparam int POINT_CYCLES  = STB_PER_POINT * MAX_PERIOD * 2;
    localparam int WATCHDOG_NS   = TOTAL_POINTS * POINT_CYCLES * CLK_NS + 20000;

    logic       clk_i, arst_i, run_i, cmp_i, dac_ack_i, point_ack_i;
    logic       dac_req_o, point_req_o, overflow_o;
    period_t    period_i;
    threshold_t threshold_delta_i, dac_data_o, point_v_o;
    dcode_t     d_code_delta_i, d_code_o, point_t_o;

    integer     seed = 32'hfe8;
    int         errors = 0;
    int         checks = 0;
    int         dac_wait;
    int         dac_writes = 0;
    int         up_hits;
    int         down_hits;
    int         flat_level = 419;
    logic       ramp_wave = 1'b0;
    logic       hold_reader = 1'b0;
    logic       first_write = 1'b1;
    logic       req_prev;
    threshold_t req_data;
    // value held by the DAC model
    threshold_t dac_level;
    threshold_t cap_v[$];
    dcode_t     cap_t[$];

    scope_channel_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

////////////////////
    task automatic check_threshold(input string name, input threshold_t got,
                                   input threshold_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_code(input string name, input dcode_t got, input dcode_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

////////////////////
    // signal level at a delay code
    function automatic int wave_at(input dcode_t code);
        if (!ramp_wave) return flat_level;
        if (code <= 40) return 200 + 24 * int'(code);
        if (code <= 80) return 200 + 24 * (80 - int'(code));
        return 200;
    endfunction

    // data held during req and each write one step from the last
    task automatic watch_dac_bus();
        threshold_t step_exp;
        if (dac_req_o && !req_prev) begin
            check_bit("dac_ack_i at request", dac_ack_i, 1'b0);
            if (first_write) begin
                check_threshold("dac_data_o first write", dac_data_o, '0);
            end else begin
                step_exp = (dac_data_o == req_data - threshold_delta_i) ?
                           req_data - threshold_delta_i : req_data + threshold_delta_i;
                check_threshold("dac_data_o step", dac_data_o, step_exp);
            end
            first_write = 1'b0;
            req_data    = dac_data_o;
            dac_writes++;
        end else if (dac_req_o) begin
            check_threshold("dac_data_o during request", dac_data_o, req_data);
        end
        req_prev = dac_req_o;
    endtask

    task automatic serve_dac();
        if (arst_i) begin
            dac_ack_i = 1'b0;
            dac_wait  = -1;
        end else if (dac_ack_i) begin
            if (!dac_req_o) dac_ack_i = 1'b0;
        end else if (dac_req_o) begin
            if (dac_wait < 0) dac_wait = ($random(seed) & 32'h7fffffff) % 6;
            if (dac_wait == 0) begin
                dac_ack_i = 1'b1;
                dac_level = dac_data_o;
                dac_wait  = -1;
            end else begin
                dac_wait--;
            end
        end
    endtask

    task automatic serve_reader();
        if (arst_i) begin
            point_ack_i = 1'b0;
            cap_v.delete();
            cap_t.delete();
        end else if (point_ack_i) begin
            if (!point_req_o) point_ack_i = 1'b0;
        end else if (point_req_o && !hold_reader) begin
            point_ack_i = 1'b1;
            cap_v.push_back(point_v_o);
            cap_t.push_back(point_t_o);
        end
    endtask

    // external models, all updated on the falling edge
    initial begin
        cmp_i       = 1'b0;
        dac_ack_i   = 1'b0;
        point_ack_i = 1'b0;
        dac_level   = '0;
        dac_wait    = -1;
        req_prev    = 1'b0;
        forever begin
            @(negedge clk_i);
            watch_dac_bus();
            serve_dac();
            cmp_i = wave_at(d_code_o) > int'(dac_level);
            serve_reader();
        end
    end

////////////////////
    task automatic reset_dut();
        @(negedge clk_i);
        arst_i = 1'b1;
        repeat (2) @(negedge clk_i);
        arst_i = 1'b0;
    endtask

    task automatic start_run();
        first_write = 1'b1;
        @(negedge clk_i);
        run_i = 1'b1;
    endtask

    // drop run, release the reader and let both handshakes settle
    task automatic stop_run();
        int quiet;
        @(negedge clk_i);
        run_i       = 1'b0;
        hold_reader = 1'b0;
        quiet       = 0;
        while (quiet < 12) begin
            @(negedge clk_i);
            quiet = (dac_req_o || dac_ack_i || point_req_o || point_ack_i) ? 0 : quiet + 1;
        end
    endtask

    task automatic wait_points(input int n);
        int cycles;
        cycles = 0;
        while (cap_t.size() < n && cycles < n * POINT_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        if (cap_t.size() < n) begin
            errors++;
            $display("timed out with %0d of %0d points read", cap_t.size(), n);
        end
    endtask

    // crossing lies within one threshold step of the level at that code
    // search runs up while the level is above the previous point
    task automatic check_point(input int idx);
        int         step;
        threshold_t upper;
        threshold_t lower;
        step  = int'(threshold_delta_i);
        upper = threshold_t'(((wave_at(cap_t[idx]) + step - 1) / step) * step);
        lower = upper - threshold_delta_i;
        check_code("point_t_o", cap_t[idx], dcode_t'(idx * int'(d_code_delta_i)));
        if (idx == 0 || wave_at(cap_t[idx]) > int'(cap_v[idx-1])) begin
            up_hits++;
            check_threshold("point_v_o", cap_v[idx], upper);
        end else begin
            down_hits++;
            check_threshold("point_v_o", cap_v[idx], lower);
        end
    endtask

    task automatic check_points();
        for (int i = 0; i < cap_t.size(); i++) begin
            check_point(i);
        end
    endtask

    task automatic configure(input logic ramp, input period_t period,
                             input threshold_t thr_step, input dcode_t code_step);
        ramp_wave         = ramp;
        period_i          = period;
        threshold_delta_i = thr_step;
        d_code_delta_i    = code_step;
        up_hits           = 0;
        down_hits         = 0;
    endtask

////////////////////
    task automatic test_idle_after_reset();
        reset_dut();
        repeat (5) @(negedge clk_i);
        check_bit("dac_req_o", dac_req_o, 1'b0);
        check_bit("point_req_o", point_req_o, 1'b0);
        check_bit("overflow_o", overflow_o, 1'b0);
        check_threshold("dac_data_o", dac_data_o, '0);
        check_code("d_code_o", d_code_o, '0);
    endtask

    task automatic test_flat_level();
        reset_dut();
        flat_level = 419;
        configure(1'b0, '0, 16'h40, 10'd3);
        start_run();
        wait_points(6);
        stop_run();
        check_points();
        check_bit("overflow_o", overflow_o, 1'b0);
    endtask

    task automatic test_ramp();
        reset_dut();
        configure(1'b1, 16'd20, 16'h40, 10'd4);
        start_run();
        wait_points(16);
        stop_run();
        check_points();
        check_bit("upward search seen", up_hits > 0, 1'b1);
        check_bit("downward search seen", down_hits > 0, 1'b1);
    endtask

    // period close to the DAC latency so some strobes are skipped
    task automatic test_dac_handshake();
        int writes_before;
        reset_dut();
        flat_level = 753;
        configure(1'b0, 16'd11, 16'h25, 10'd2);
        writes_before = dac_writes;
        start_run();
        wait_points(4);
        stop_run();
        check_points();
        check_bit("DAC writes observed", (dac_writes - writes_before) > 4, 1'b1);
    endtask

    task automatic test_overflow();
        int cycles;
        reset_dut();
        flat_level = 419;
        configure(1'b0, 16'd10, 16'h40, 10'd1);
        hold_reader = 1'b1;
        start_run();
        cycles = 0;
        while (!overflow_o && cycles < 12 * POINT_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        check_bit("overflow_o", overflow_o, 1'b1);
        stop_run();
        check_count("points after overflow", cap_t.size(), `POINT_FIFO_DEPTH);
        check_points();
        check_bit("overflow_o after drain", overflow_o, 1'b1);
    endtask

    task automatic test_restart();
        reset_dut();
        flat_level = 419;
        configure(1'b0, '0, 16'h40, 10'd5);
        start_run();
        wait_points(2);
        stop_run();
        // restart with no reset in between
        cap_v.delete();
        cap_t.delete();
        start_run();
        @(negedge clk_i);
        check_code("d_code_o after restart", d_code_o, '0);
        wait_points(2);
        stop_run();
        check_points();
    endtask

////////////////////
    initial begin
        arst_i            = 1'b1;
        run_i             = 1'b0;
        period_i          = '0;
        threshold_delta_i = 16'h40;
        d_code_delta_i    = 10'd1;
        test_idle_after_reset();
        test_flat_level();
        test_ramp();
        test_dac_handshake();
        test_overflow();
        test_restart();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished, %0d errors", errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
trace_pkg.sv
strobe_gen.sv
dac_link.sv
ch_measure_ctl.sv
point_fifo.sv
scope_channel_top.sv
tb_scope_channel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the scope channel testbench with Verilator

LOG=sim.log

verilator --binary --timing -j 0 -f sim.f --top-module tb_scope_channel \
    --Mdir obj_dir -o tb_scope_channel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_scope_channel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
